// ==== include/conv_acc_defines.svh ====
`ifndef CONV_ACC_DEFINES_SVH
`define CONV_ACC_DEFINES_SVH

// ==============================
// Widths and buffer geometry
// ==============================
`define DATA_W     32
`define ADDR_W     12
`define IN_DEPTH   256  // A in lower half, B in upper half.
`define IN_AW      8
`define OUT_DEPTH  16
`define OUT_AW     4

// ==============================
// Address map
// ==============================
`define RGN_REG    2'd0  // paddr[11:10].
`define RGN_IN     2'd1
`define RGN_OUT    2'd2
`define REG_CTRL   10'h000
`define REG_LEN    10'h004
`define REG_STATUS 10'h008

`endif

// ==== design/conv_acc_pkg.sv ====
`default_nettype none

package conv_acc_pkg;

  // Job opcodes, CTRL bits 2:1.
  typedef enum logic [1:0] {
    OP_SUM = 2'd0,
    OP_DOT = 2'd1,
    OP_MAX = 2'd2
  } op_e;

  // Owner of the input SRAM.
  typedef enum logic [2:0] {
    W_IDLE   = 3'd0,
    W_BUS    = 3'd1,
    W_ENGINE = 3'd2
  } wrap_state_e;

  typedef enum logic [2:0] {
    E_IDLE       = 3'd0,
    E_WAIT_GRANT = 3'd1,
    E_READ_A     = 3'd2,
    E_READ_B     = 3'd3,  // Dot only.
    E_ACCUM      = 3'd4,
    E_WRITE      = 3'd5
  } eng_state_e;

endpackage

`default_nettype wire

// ==== design/buffer_sram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_acc_defines.svh"

module buffer_sram #(
  parameter int DEPTH = `IN_DEPTH,
  parameter int WIDTH = `DATA_W
) (
  input  logic                     clk,
  input  logic                     cs_i,
  input  logic                     we_i,
  input  logic [$clog2(DEPTH)-1:0] addr_i,
  input  logic [WIDTH-1:0]         wdata_i,
  output logic [WIDTH-1:0]         rdata_o
);

  localparam int AW = $clog2(DEPTH);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    addr;

  assign addr = addr_i;

  always_ff @(posedge clk) begin
    if (cs_i && we_i) begin
      mem[addr] <= wdata_i;
    end else if (cs_i) begin
      rdata_o <= mem[addr];  // One cycle read latency.
    end
  end

endmodule

`default_nettype wire

// ==== design/apb_reg_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_acc_defines.svh"

module apb_reg_decode (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    psel_i,
  input  logic                    penable_i,
  input  logic                    pwrite_i,
  input  logic [`ADDR_W-1:0]      paddr_i,
  input  logic [`DATA_W-1:0]      pwdata_i,
  output logic [`DATA_W-1:0]      prdata_o,
  output logic                    pready_o,
  output logic                    pslverr_o,
  output logic                    bus_in_req_o,
  output logic                    bus_in_we_o,
  output logic [`IN_AW-1:0]       bus_in_addr_o,
  output logic [`DATA_W-1:0]      bus_in_wdata_o,
  input  logic [`DATA_W-1:0]      bus_in_rdata_i,
  input  logic                    bus_in_busy_i,
  output logic [`OUT_AW-1:0]      out_addr_o,
  input  logic [`DATA_W-1:0]      out_rdata_i,
  output logic                    start_o,
  output conv_acc_pkg::op_e       op_o,
  output logic [`IN_AW-1:0]       len_o,
  input  logic                    busy_i,
  input  logic                    done_i
);

  logic                 access;
  logic                 acc_q;   // Second access cycle.
  logic                 err_q;   // Input buffer refused.
  logic                 wr_done;
  logic                 in_rgn;
  logic [1:0]           region;
  logic [9:0]           offset;
  logic [`DATA_W-1:0]   rd_mux;
  conv_acc_pkg::op_e    op_q;
  logic [`IN_AW-1:0]    len_q;
  logic                 start_q;

  assign region  = paddr_i[`ADDR_W-1:`ADDR_W-2];
  assign offset  = paddr_i[`ADDR_W-3:0];
  assign in_rgn  = (region == `RGN_IN);
  assign access  = psel_i & penable_i;
  assign pready_o  = access & acc_q;
  assign pslverr_o = pready_o & err_q;
  assign wr_done   = pready_o & pwrite_i;

  // Refused accesses never reach the wrapper in their last cycle.
  assign bus_in_req_o   = access & in_rgn & ~(acc_q & err_q);
  assign bus_in_we_o    = pwrite_i;
  assign bus_in_addr_o  = paddr_i[`IN_AW+1:2];
  assign bus_in_wdata_o = pwdata_i;
  assign out_addr_o     = paddr_i[`OUT_AW+1:2];

  assign start_o = start_q;
  assign op_o    = op_q;
  assign len_o   = len_q;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      acc_q   <= 1'b0;
      err_q   <= 1'b0;
      start_q <= 1'b0;
      op_q    <= conv_acc_pkg::OP_SUM;
      len_q   <= '0;
    end else begin
      acc_q   <= access & ~acc_q;
      if (access && !acc_q) begin
        err_q <= in_rgn & bus_in_busy_i;  // Sampled in the first access cycle.
      end
      start_q <= wr_done && (region == `RGN_REG) && (offset == `REG_CTRL) &&
                 pwdata_i[0] && !busy_i;
      if (wr_done && region == `RGN_REG) begin
        case (offset)
          `REG_CTRL: op_q  <= conv_acc_pkg::op_e'(pwdata_i[2:1]);
          `REG_LEN:  len_q <= pwdata_i[`IN_AW-1:0];
          default: ;
        endcase
      end
    end
  end

  // ==============================
  // Read data select
  // ==============================
  always_comb begin
    rd_mux = '0;
    case (region)
      `RGN_REG: begin
        case (offset)
          `REG_CTRL:   rd_mux[2:1] = op_q;
          `REG_LEN:    rd_mux[`IN_AW-1:0] = len_q;
          `REG_STATUS: rd_mux[1:0] = {done_i, busy_i};
          default: ;
        endcase
      end
      `RGN_IN:  if (!err_q) rd_mux = bus_in_rdata_i;
      `RGN_OUT: rd_mux = out_rdata_i;
      default: ;
    endcase
  end

  assign prdata_o = pready_o ? rd_mux : '0;

endmodule

`default_nettype wire

// ==== design/input_buffer_wrapper.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_acc_defines.svh"

module input_buffer_wrapper (
  input  logic                 clk,
  input  logic                 rst,
  // Bus side.
  input  logic                 bus_in_req_i,
  input  logic                 bus_in_we_i,
  input  logic [`IN_AW-1:0]    bus_in_addr_i,
  input  logic [`DATA_W-1:0]   bus_in_wdata_i,
  output logic [`DATA_W-1:0]   bus_in_rdata_o,
  output logic                 bus_in_busy_o,
  // Engine side.
  input  logic                 eng_req_i,
  input  logic [`IN_AW-1:0]    eng_addr_i,
  output logic                 eng_gnt_o,
  output logic [`DATA_W-1:0]   eng_rdata_o
);

  conv_acc_pkg::wrap_state_e state_q, state_d;

  logic                sram_cs;
  logic                sram_we;
  logic [`IN_AW-1:0]   sram_addr;
  logic [`DATA_W-1:0]  sram_wdata;
  logic [`DATA_W-1:0]  sram_rdata;

  buffer_sram #(
    .DEPTH (`IN_DEPTH),
    .WIDTH (`DATA_W)
  ) u_in_sram (
    .clk     (clk),
    .cs_i    (sram_cs),
    .we_i    (sram_we),
    .addr_i  (sram_addr),
    .wdata_i (sram_wdata),
    .rdata_o (sram_rdata)
  );

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state_q <= conv_acc_pkg::W_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      conv_acc_pkg::W_IDLE: begin
        if (bus_in_req_i) state_d = conv_acc_pkg::W_BUS;  // Bus wins a tie.
        else if (eng_req_i) state_d = conv_acc_pkg::W_ENGINE;
      end
      conv_acc_pkg::W_BUS:    if (!bus_in_req_i) state_d = conv_acc_pkg::W_IDLE;
      conv_acc_pkg::W_ENGINE: if (!eng_req_i) state_d = conv_acc_pkg::W_IDLE;
      default: state_d = conv_acc_pkg::W_IDLE;
    endcase
  end

  // ==============================
  // SRAM port mux
  // ==============================
  always_comb begin
    if (state_q == conv_acc_pkg::W_ENGINE) begin
      sram_cs    = eng_req_i;
      sram_we    = 1'b0;  // Engine only reads.
      sram_addr  = eng_addr_i;
      sram_wdata = '0;
    end else begin
      // Bus gets the port already in idle so read data lands in the wait state.
      sram_cs    = bus_in_req_i;
      sram_we    = bus_in_req_i & bus_in_we_i;
      sram_addr  = bus_in_addr_i;
      sram_wdata = bus_in_wdata_i;
    end
  end

  assign bus_in_rdata_o = (state_q == conv_acc_pkg::W_BUS) ? sram_rdata : '0;
  assign eng_rdata_o    = (state_q == conv_acc_pkg::W_ENGINE) ? sram_rdata : '0;
  assign bus_in_busy_o  = (state_q == conv_acc_pkg::W_ENGINE);
  assign eng_gnt_o      = (state_q == conv_acc_pkg::W_ENGINE);

endmodule

`default_nettype wire

// ==== design/mac_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_acc_defines.svh"

module mac_engine (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 start_i,
  input  conv_acc_pkg::op_e    op_i,
  input  logic [`IN_AW-1:0]    len_i,
  input  logic                 eng_gnt_i,
  input  logic [`DATA_W-1:0]   eng_rdata_i,
  output logic                 eng_req_o,
  output logic [`IN_AW-1:0]    eng_addr_o,
  output logic                 busy_o,
  output logic                 done_o,
  output logic                 res_we_o,
  output logic [`DATA_W-1:0]   res_data_o
);

  conv_acc_pkg::eng_state_e state_q, state_d;
  conv_acc_pkg::op_e        op_q;

  logic [`IN_AW-1:0]     idx_q;
  logic [`IN_AW-1:0]     last_idx_q;
  logic                  last;
  logic                  done_q;
  logic                  start_ok;
  logic [`DATA_W-1:0]    acc_q, acc_d;
  logic [`DATA_W-1:0]    a_q;  // Operand A for dot.
  logic [`DATA_W-1:0]    prod;  // Low half of the product.

  assign last     = (idx_q == last_idx_q);
  assign start_ok = (state_q == conv_acc_pkg::E_IDLE) && start_i;
  assign prod     = a_q * eng_rdata_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      conv_acc_pkg::E_IDLE:       if (start_i) state_d = conv_acc_pkg::E_WAIT_GRANT;
      conv_acc_pkg::E_WAIT_GRANT: if (eng_gnt_i) state_d = conv_acc_pkg::E_READ_A;
      conv_acc_pkg::E_READ_A: begin
        state_d = (op_q == conv_acc_pkg::OP_DOT) ? conv_acc_pkg::E_READ_B
                                                 : conv_acc_pkg::E_ACCUM;
      end
      conv_acc_pkg::E_READ_B: state_d = conv_acc_pkg::E_ACCUM;
      conv_acc_pkg::E_ACCUM:  state_d = last ? conv_acc_pkg::E_WRITE : conv_acc_pkg::E_READ_A;
      conv_acc_pkg::E_WRITE:  state_d = conv_acc_pkg::E_IDLE;
      default:                state_d = conv_acc_pkg::E_IDLE;
    endcase
  end

  // ==============================
  // Reduction
  // ==============================
  always_comb begin
    case (op_q)
      conv_acc_pkg::OP_DOT: acc_d = acc_q + prod;
      conv_acc_pkg::OP_MAX: begin
        acc_d = (idx_q == '0 || $signed(eng_rdata_i) > $signed(acc_q)) ? eng_rdata_i : acc_q;
      end
      default: acc_d = acc_q + eng_rdata_i;  // Wraps mod 2^32.
    endcase
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state_q    <= conv_acc_pkg::E_IDLE;
      op_q       <= conv_acc_pkg::OP_SUM;
      idx_q      <= '0;
      last_idx_q <= '0;
      done_q     <= 1'b0;
    end else begin
      state_q <= state_d;
      if (start_ok) begin
        op_q       <= op_i;
        idx_q      <= '0;
        last_idx_q <= (len_i == '0) ? '0 : len_i - 1'b1;  // Zero length runs once.
        done_q     <= 1'b0;
      end
      if (state_q == conv_acc_pkg::E_ACCUM) idx_q <= idx_q + 1'b1;
      if (state_q == conv_acc_pkg::E_WRITE) done_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (start_ok) acc_q <= '0;
    else if (state_q == conv_acc_pkg::E_ACCUM) acc_q <= acc_d;
    if (state_q == conv_acc_pkg::E_READ_B) a_q <= eng_rdata_i;
  end

  // Held until the last operand has been read.
  assign eng_req_o = (state_q == conv_acc_pkg::E_WAIT_GRANT) ||
                     (state_q == conv_acc_pkg::E_READ_A) ||
                     (state_q == conv_acc_pkg::E_READ_B) ||
                     (state_q == conv_acc_pkg::E_ACCUM && !last);
  assign eng_addr_o = (state_q == conv_acc_pkg::E_READ_B) ? {1'b1, idx_q[`IN_AW-2:0]}
                                                          : idx_q;
  assign busy_o     = (state_q != conv_acc_pkg::E_IDLE);
  assign done_o     = done_q;
  assign res_we_o   = (state_q == conv_acc_pkg::E_WRITE);
  assign res_data_o = acc_q;

endmodule

`default_nettype wire

// ==== design/output_result_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_acc_defines.svh"

module output_result_buffer (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 res_we_i,
  input  logic [`DATA_W-1:0]   res_data_i,
  input  logic [`OUT_AW-1:0]   rd_addr_i,
  output logic [`DATA_W-1:0]   rd_data_o
);

  logic [`OUT_AW-1:0] wr_ptr_q;
  logic [`OUT_AW-1:0] sram_addr;

  // ==============================
  // Result ring
  // ==============================
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      wr_ptr_q <= '0;
    end else if (res_we_i) begin
      wr_ptr_q <= wr_ptr_q + 1'b1;  // Wraps at OUT_DEPTH.
    end
  end

  // Result write takes the port over a bus read.
  assign sram_addr = res_we_i ? wr_ptr_q : rd_addr_i;

  buffer_sram #(
    .DEPTH (`OUT_DEPTH),
    .WIDTH (`DATA_W)
  ) u_out_sram (
    .clk     (clk),
    .cs_i    (1'b1),
    .we_i    (res_we_i),
    .addr_i  (sram_addr),
    .wdata_i (res_data_i),
    .rdata_o (rd_data_o)
  );

endmodule

`default_nettype wire

// ==== design/conv_acc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_acc_defines.svh"

module conv_acc_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 psel_i,
  input  logic                 penable_i,
  input  logic                 pwrite_i,
  input  logic [`ADDR_W-1:0]   paddr_i,
  input  logic [`DATA_W-1:0]   pwdata_i,
  output logic [`DATA_W-1:0]   prdata_o,
  output logic                 pready_o,
  output logic                 pslverr_o,
  output logic                 done_o
);

  // ==============================
  // Interconnect
  // ==============================
  logic                bus_in_req, bus_in_we, bus_in_busy;
  logic [`IN_AW-1:0]   bus_in_addr;
  logic [`DATA_W-1:0]  bus_in_wdata, bus_in_rdata;
  logic                eng_req, eng_gnt;
  logic [`IN_AW-1:0]   eng_addr;
  logic [`DATA_W-1:0]  eng_rdata;
  logic [`OUT_AW-1:0]  out_addr;
  logic [`DATA_W-1:0]  out_rdata;
  logic                start, busy, res_we;
  logic [`IN_AW-1:0]   len;
  logic [`DATA_W-1:0]  res_data;
  conv_acc_pkg::op_e   op;

  apb_reg_decode u_apb_reg_decode (
    .clk (clk), .rst (rst),
    .psel_i (psel_i), .penable_i (penable_i), .pwrite_i (pwrite_i),
    .paddr_i (paddr_i), .pwdata_i (pwdata_i),
    .prdata_o (prdata_o), .pready_o (pready_o), .pslverr_o (pslverr_o),
    .bus_in_req_o (bus_in_req), .bus_in_we_o (bus_in_we),
    .bus_in_addr_o (bus_in_addr), .bus_in_wdata_o (bus_in_wdata),
    .bus_in_rdata_i (bus_in_rdata), .bus_in_busy_i (bus_in_busy),
    .out_addr_o (out_addr), .out_rdata_i (out_rdata),
    .start_o (start), .op_o (op), .len_o (len),
    .busy_i (busy), .done_i (done_o)
  );

  input_buffer_wrapper u_input_buffer_wrapper (
    .clk (clk), .rst (rst),
    .bus_in_req_i (bus_in_req), .bus_in_we_i (bus_in_we),
    .bus_in_addr_i (bus_in_addr), .bus_in_wdata_i (bus_in_wdata),
    .bus_in_rdata_o (bus_in_rdata), .bus_in_busy_o (bus_in_busy),
    .eng_req_i (eng_req), .eng_addr_i (eng_addr),
    .eng_gnt_o (eng_gnt), .eng_rdata_o (eng_rdata)
  );

  mac_engine u_mac_engine (
    .clk (clk), .rst (rst),
    .start_i (start), .op_i (op), .len_i (len),
    .eng_gnt_i (eng_gnt), .eng_rdata_i (eng_rdata),
    .eng_req_o (eng_req), .eng_addr_o (eng_addr),
    .busy_o (busy), .done_o (done_o),
    .res_we_o (res_we), .res_data_o (res_data)
  );

  output_result_buffer u_output_result_buffer (
    .clk (clk), .rst (rst),
    .res_we_i (res_we), .res_data_i (res_data),
    .rd_addr_i (out_addr), .rd_data_o (out_rdata)
  );

endmodule

`default_nettype wire

// ==== tests/conv_acc_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_acc_defines.svh"

module conv_acc_tb;

  localparam int MAX_CYCLES = 20000;  // About 20 jobs of up to 64 dot elements.
  localparam logic [`ADDR_W-1:0] A_CTRL   = 12'h000;
  localparam logic [`ADDR_W-1:0] A_LEN    = 12'h004;
  localparam logic [`ADDR_W-1:0] A_STATUS = 12'h008;

  logic                clk;
  logic                rst;
  logic                psel_i;
  logic                penable_i;
  logic                pwrite_i;
  logic [`ADDR_W-1:0]  paddr_i;
  logic [`DATA_W-1:0]  pwdata_i;
  logic [`DATA_W-1:0]  prdata_o;
  logic                pready_o;
  logic                pslverr_o;
  logic                done_o;

  logic [`DATA_W-1:0]  in_model [`IN_DEPTH];
  logic [`DATA_W-1:0]  res_model [`OUT_DEPTH];
  logic                res_valid [`OUT_DEPTH];
  int                  errors = 0;
  int                  checks = 0;
  int                  jobs = 0;
  int                  cycles = 0;

  conv_acc_top u_conv_acc_top (
    .clk (clk), .rst (rst),
    .psel_i (psel_i), .penable_i (penable_i), .pwrite_i (pwrite_i),
    .paddr_i (paddr_i), .pwdata_i (pwdata_i),
    .prdata_o (prdata_o), .pready_o (pready_o), .pslverr_o (pslverr_o),
    .done_o (done_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Run stopped by timeout after %0d cycles with %0d errors", cycles, errors);
      $display("Test failed");
      $finish;
    end
  end

  // ==============================
  // APB protocol checks
  // ==============================
  assert property (@(posedge clk) disable iff (rst) (psel_i && !penable_i) |=> !pready_o)
    else begin
      errors++;
      $display("FAIL t=%0t pready_o expected 0 actual 1", $time);
    end
  assert property (@(posedge clk) disable iff (rst)
                   (psel_i && penable_i && !pready_o) |=> pready_o)
    else begin
      errors++;
      $display("FAIL t=%0t pready_o expected 1 actual 0", $time);
    end
  assert property (@(posedge clk) disable iff (rst) pslverr_o |-> pready_o)
    else begin
      errors++;
      $display("FAIL t=%0t pslverr_o raised without pready_o", $time);
    end

  function automatic logic [`ADDR_W-1:0] in_addr(input int idx);
    return {`RGN_IN, 10'(idx * 4)};
  endfunction

  function automatic logic [`ADDR_W-1:0] out_addr(input int slot);
    return {`RGN_OUT, 10'(slot * 4)};
  endfunction

  task automatic compare_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("FAIL t=%0t %s expected 0x%08h actual 0x%08h", $time, name, exp, act);
    end
  endtask

  // One transfer. Samples at the falling edge.
  task automatic apb_xfer(input logic wr, input logic [`ADDR_W-1:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic err);
    int waits;
    @(posedge clk);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= wr;
    paddr_i   <= addr;
    pwdata_i  <= wdata;
    @(posedge clk);
    penable_i <= 1'b1;
    waits = 0;
    @(negedge clk);
    while (!pready_o && waits < 8) begin
      @(negedge clk);
      waits++;
    end
    if (!pready_o) begin
      errors++;
      $display("APB transfer to 0x%03h never got pready_o at t=%0t", addr, $time);
    end
    rdata = prdata_o;
    err   = pslverr_o;
    @(posedge clk);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
  endtask

  task automatic bus_write(input logic [`ADDR_W-1:0] addr, input logic [31:0] data,
                           input logic exp_err);
    logic [31:0] rd;
    logic        err;
    apb_xfer(1'b1, addr, data, rd, err);
    compare_word("pslverr_o", {31'd0, exp_err}, {31'd0, err});
  endtask

  task automatic bus_read(input logic [`ADDR_W-1:0] addr, input logic exp_err,
                          output logic [31:0] data);
    logic err;
    apb_xfer(1'b0, addr, 32'd0, data, err);
    compare_word("pslverr_o", {31'd0, exp_err}, {31'd0, err});
  endtask

  // ==============================
  // Jobs and reference model
  // ==============================
  task automatic load_job(input conv_acc_pkg::op_e op, input int len, input logic neg,
                          output logic [31:0] exp);
    int          n;
    logic [31:0] a;
    logic [31:0] b;
    n = (len == 0) ? 1 : len;  // Zero length runs one element.
    for (int i = 0; i < n; i++) begin
      a = $urandom;
      b = $urandom;
      if (neg) a[31] = 1'b1;
      bus_write(in_addr(i), a, 1'b0);
      in_model[i] = a;
      if (op == conv_acc_pkg::OP_DOT) begin
        bus_write(in_addr(`IN_DEPTH/2 + i), b, 1'b0);
        in_model[`IN_DEPTH/2 + i] = b;
      end
    end
    exp = (op == conv_acc_pkg::OP_MAX) ? in_model[0] : 32'd0;  // Max starts from element 0.
    for (int i = 0; i < n; i++) begin
      case (op)
        conv_acc_pkg::OP_SUM: exp = exp + in_model[i];
        conv_acc_pkg::OP_DOT: exp = exp + in_model[i] * in_model[`IN_DEPTH/2 + i];
        default: begin
          if ($signed(in_model[i]) > $signed(exp)) exp = in_model[i];
        end
      endcase
    end
  endtask

  task automatic start_job(input conv_acc_pkg::op_e op, input int len);
    if (jobs > 0) compare_word("done_o", 32'd1, {31'd0, done_o});  // Still sticky.
    bus_write(A_LEN, 32'(len), 1'b0);
    bus_write(A_CTRL, {29'd0, op, 1'b1}, 1'b0);
    @(negedge clk);
    @(negedge clk);
    compare_word("done_o", 32'd0, {31'd0, done_o});
  endtask

  task automatic finish_job(input int len, input logic [31:0] exp);
    int          n;
    int          waited;
    int          slot;
    logic [31:0] rd;
    n = (len == 0) ? 1 : len;
    waited = 0;
    while (!done_o && waited < 3 * n + 8) begin
      @(negedge clk);
      waited++;
    end
    if (!done_o) begin
      errors++;
      $display("Job %0d did not finish within %0d cycles", jobs, 3 * n + 8);
    end
    slot = jobs % `OUT_DEPTH;
    res_model[slot] = exp;
    res_valid[slot] = 1'b1;
    jobs++;
    bus_read(out_addr(slot), 1'b0, rd);
    compare_word("result slot", exp, rd);
    bus_read(A_STATUS, 1'b0, rd);
    compare_word("STATUS", 32'h2, rd);
  endtask

  task automatic run_job(input conv_acc_pkg::op_e op, input int len, input logic neg);
    logic [31:0] exp;
    load_job(op, len, neg, exp);
    start_job(op, len);
    finish_job(len, exp);
  endtask

  task automatic check_ring();
    logic [31:0] rd;
    for (int s = 0; s < `OUT_DEPTH; s++) begin
      if (res_valid[s]) begin
        bus_read(out_addr(s), 1'b0, rd);
        compare_word("result ring", res_model[s], rd);
      end
    end
  endtask

  initial begin
    logic [31:0] rd;
    logic [31:0] exp;
    logic [31:0] wv;
    int          idx;
    int          len;
    int          touched[$];
    void'($urandom(41));
    rst       = 1'b1;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    paddr_i   = '0;
    pwdata_i  = '0;
    for (int s = 0; s < `OUT_DEPTH; s++) res_valid[s] = 1'b0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);

    // After reset.
    compare_word("pready_o", 32'd0, {31'd0, pready_o});
    compare_word("pslverr_o", 32'd0, {31'd0, pslverr_o});
    compare_word("done_o", 32'd0, {31'd0, done_o});
    bus_read(A_STATUS, 1'b0, rd);
    compare_word("STATUS", 32'd0, rd);

    // Input buffer read-back while idle.
    for (int i = 0; i < 24; i++) begin
      idx = $urandom_range(0, `IN_DEPTH - 1);
      wv  = $urandom;
      bus_write(in_addr(idx), wv, 1'b0);
      in_model[idx] = wv;
      touched.push_back(idx);
    end
    foreach (touched[i]) begin
      bus_read(in_addr(touched[i]), 1'b0, rd);
      compare_word("input buffer", in_model[touched[i]], rd);
    end

    // One job per opcode, max also with all negative operands.
    run_job(conv_acc_pkg::OP_SUM, $urandom_range(1, 64), 1'b0);
    run_job(conv_acc_pkg::OP_DOT, $urandom_range(1, 64), 1'b0);
    run_job(conv_acc_pkg::OP_MAX, $urandom_range(2, 64), 1'b0);
    run_job(conv_acc_pkg::OP_MAX, $urandom_range(2, 64), 1'b1);

    // Short jobs until the ring wraps.
    for (int i = 0; i < 14; i++) begin
      len = (i == 5) ? 0 : $urandom_range(1, 8);
      run_job(conv_acc_pkg::op_e'(2'(i % 3)), len, 1'(i % 2));
      if (jobs == `OUT_DEPTH) check_ring();
    end
    check_ring();

    // Bus traffic during a long dot job.
    bus_write(in_addr(250), 32'h5a5a_c3c3, 1'b0);
    in_model[250] = 32'h5a5a_c3c3;
    load_job(conv_acc_pkg::OP_DOT, 64, 1'b0, exp);
    start_job(conv_acc_pkg::OP_DOT, 64);
    bus_read(A_STATUS, 1'b0, rd);
    compare_word("STATUS", 32'h1, rd);
    bus_write(in_addr(250), ~in_model[250], 1'b1);
    bus_read(in_addr(250), 1'b1, rd);
    compare_word("refused read data", 32'd0, rd);
    bus_write(A_CTRL, {29'd0, conv_acc_pkg::OP_SUM, 1'b1}, 1'b0);  // Should be ignored.
    finish_job(64, exp);
    bus_read(in_addr(250), 1'b0, rd);
    compare_word("input buffer", in_model[250], rd);

    // Done holds until the next start.
    repeat (20) begin
      @(negedge clk);
      compare_word("done_o", 32'd1, {31'd0, done_o});
    end
    run_job(conv_acc_pkg::OP_SUM, $urandom_range(1, 16), 1'b0);
    check_ring();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== conv_acc_top.f ====
+incdir+include
design/conv_acc_pkg.sv
design/buffer_sram.sv
design/apb_reg_decode.sv
design/input_buffer_wrapper.sv
design/mac_engine.sv
design/output_result_buffer.sv
design/conv_acc_top.sv
tests/conv_acc_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f conv_acc_top.f --top-module conv_acc_tb -o conv_acc_sim

./obj_dir/conv_acc_sim | tee sim.log

if grep -q "^Test passed$" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
